//--- design/qsnd_pkg.sv
`default_nettype none

package qsnd_pkg;

    localparam int addr_w = 16;  // sound CPU address bus
    localparam int rom_aw = 19;  // 512 kB program ROM
    localparam int word_w = 16;  // DSP parallel and sample words
    localparam int bank_w = 4;

    // top nibble of the CPU address
    localparam logic [3:0] rgn_ram_lo = 4'hc;
    localparam logic [3:0] rgn_ram_hi = 4'hf;
    localparam logic [3:0] rgn_regs   = 4'hd;

    localparam logic [rom_aw-1:0] bank_base = 19'h08000;  // banked window starts here

    // one CPU address seen as a memory region or as a register slot
    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [11:0] offset;
        } mem;
        struct packed {
            logic [12:0] page;
            logic [2:0]  idx;
        } regv;
    } z80_addr_u;

endpackage

`default_nettype wire

//--- design/z80_map_decode.sv
`timescale 1ns/1ns
`default_nettype none

module z80_map_decode (
    input  wire                           clk48,
    input  wire                           rst,
    input  wire  [qsnd_pkg::addr_w-1:0]   addr,
    input  wire                           mreq_n,
    input  wire                           rd_n,
    input  wire                           wr_n,
    input  wire  [7:0]                    cpu_dout,
    input  wire  [qsnd_pkg::bank_w-1:0]   bank,
    input  wire  [7:0]                    status,
    input  wire  [7:0]                    rom_data,
    output logic                          rom_cs,
    output logic [qsnd_pkg::rom_aw-1:0]   rom_addr,
    output logic                          ram_cs,
    output logic                          reg_wr,
    output logic                          bank_wr,
    output logic                          stat_rd,
    output logic [2:0]                    reg_idx,
    output logic [7:0]                    reg_data,
    output logic [7:0]                    cpu_din
);

    typedef logic [qsnd_pkg::rom_aw-1:0] rom_addr_t;

    qsnd_pkg::z80_addr_u a;
    logic                in_regs;

    assign a       = addr;
    assign in_regs = a.mem.region == qsnd_pkg::rgn_regs;

    // selects lag the bus by one cycle
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            reg_wr  <= 1'b0;
            bank_wr <= 1'b0;
            stat_rd <= 1'b0;
        end else begin
            rom_cs  <= !mreq_n && a.mem.region < qsnd_pkg::rgn_ram_lo;  // 0000-bfff
            ram_cs  <= !mreq_n && (a.mem.region == qsnd_pkg::rgn_ram_lo ||
                                   a.mem.region == qsnd_pkg::rgn_ram_hi);
            reg_wr  <= !mreq_n && !wr_n && in_regs && a.regv.idx <= 3'd2;
            bank_wr <= !mreq_n && !wr_n && in_regs && a.regv.idx == 3'd3;
            stat_rd <= !mreq_n && !rd_n && in_regs && a.regv.idx == 3'd7;
        end
    end

    always_ff @(posedge clk48) begin
        if (!mreq_n) begin
            if (a.mem.region[3])  // 8000-bfff goes through the bank
                rom_addr <= qsnd_pkg::bank_base +
                            rom_addr_t'({bank, a.mem.region[1:0], a.mem.offset});
            else
                rom_addr <= rom_addr_t'({a.mem.region[2:0], a.mem.offset});
            reg_idx  <= a.regv.idx;
            reg_data <= cpu_dout;
        end
    end

    always_comb begin
        if (rom_cs)
            cpu_din = rom_data;
        else if (stat_rd)
            cpu_din = status;
        else
            cpu_din = 8'hff;  // open bus
    end

    // the map regions never overlap
    a_one_select: assert property (@(posedge clk48) disable iff (rst)
        $onehot0({rom_cs, ram_cs, reg_wr, bank_wr, stat_rd}));

endmodule

`default_nettype wire

//--- design/dsp_mailbox.sv
`timescale 1ns/1ns
`default_nettype none

module dsp_mailbox (
    input  wire                           clk48,
    input  wire                           rst,
    input  wire                           reg_wr,
    input  wire                           bank_wr,
    input  wire  [2:0]                    reg_idx,
    input  wire  [7:0]                    reg_data,
    input  wire                           pids_n,
    input  wire                           iack,
    output logic [qsnd_pkg::bank_w-1:0]   bank,
    output logic                          dsp_rst,
    output logic                          dsp_irq,
    output logic [qsnd_pkg::word_w-1:0]   pbus_in,
    output logic [7:0]                    status
);

    logic [qsnd_pkg::word_w-1:0] data_word;
    logic [7:0]                  addr_byte;
    logic [1:0]                  sel;        // msb set while the address is offered
    logic                        last_pids_n;
    logic                        pids_rise;
    logic                        rdy_n;

    assign pids_rise = pids_n && !last_pids_n;
    assign rdy_n     = ~(dsp_irq | iack);
    assign status    = {rdy_n, 3'b111, bank};

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank        <= '0;
            dsp_rst     <= 1'b1;
            dsp_irq     <= 1'b0;
            sel         <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= pids_n;
            if (bank_wr) begin
                bank    <= reg_data[qsnd_pkg::bank_w-1:0];
                dsp_rst <= ~reg_data[7];  // bit 7 lets the DSP run
            end
            if (reg_wr && reg_idx == 3'd2) begin
                dsp_irq <= 1'b1;
                sel     <= 2'b11;
            end else if (pids_rise) begin
                // DSP took one word so step to the next
                dsp_irq <= 1'b0;
                sel     <= sel >> 1;
            end
        end
    end

    always_ff @(posedge clk48) begin
        if (reg_wr) begin
            case (reg_idx)
                3'd0:    data_word[15:8] <= reg_data;
                3'd1:    data_word[7:0]  <= reg_data;
                3'd2:    addr_byte       <= reg_data;
                default: ;
            endcase
        end
    end

    assign pbus_in = sel[1] ? {8'd0, addr_byte} : data_word;

    // a request to a DSP held in reset only survives the write cycle
    a_irq_in_reset: assert property (@(posedge clk48) disable iff (rst)
        (dsp_irq && dsp_rst) |=> !(dsp_irq && dsp_rst));

endmodule

`default_nettype wire

//--- design/z80_tick_irq.sv
`timescale 1ns/1ns
`default_nettype none

module z80_tick_irq #(
    parameter int TICK_PERIOD = 32000
) (
    input  wire  clk48,
    input  wire  rst,
    input  wire  cen8,
    input  wire  m1_n,
    input  wire  iorq_n,
    output logic int_n
);

    localparam int cw = $clog2(TICK_PERIOD);

    logic [cw-1:0] cnt;
    logic          wrap;

    assign wrap = cnt == cw'(TICK_PERIOD - 1);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= wrap ? '0 : cnt + 1'b1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;  // acknowledge cycle
            else if (wrap)
                int_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/serial_word_steer.sv
`timescale 1ns/1ns
`default_nettype none

module serial_word_steer #(
    parameter int NCH = 2
) (
    input  wire                           clk48,
    input  wire                           rst,
    input  wire                           sadd,
    input  wire                           psel,
    input  wire  [qsnd_pkg::word_w-1:0]   ser_out,
    output logic [NCH-1:0]                load,
    output logic [qsnd_pkg::word_w-1:0]   word
);

    logic last_sadd;
    logic word_end;

    assign word_end = !sadd && last_sadd;  // sadd falls after the last bit

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_sadd <= 1'b0;
            load      <= '0;
        end else begin
            last_sadd <= sadd;
            for (int i = 0; i < NCH; i++)
                load[i] <= word_end && int'(psel) == i;
        end
    end

    always_ff @(posedge clk48) begin
        if (word_end)
            word <= ser_out;  // parallel copy of the finished word
    end

    a_load_onehot: assert property (@(posedge clk48) disable iff (rst) $onehot0(load));

endmodule

`default_nettype wire

//--- design/chan_hold.sv
`timescale 1ns/1ns
`default_nettype none

module chan_hold #(
    parameter int chan_index = 0
) (
    input  wire                           clk48,
    input  wire                           rst,
    input  wire                           load,
    input  wire  [qsnd_pkg::word_w-1:0]   word,
    input  wire                           clear,
    output logic [qsnd_pkg::word_w-1:0]   held,
    output logic                          fresh
);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst)
            fresh <= 1'b0;
        else if (load)
            fresh <= 1'b1;  // a new word wins over the clear
        else if (clear)
            fresh <= 1'b0;
    end

    always_ff @(posedge clk48) begin
        if (load)
            held <= word;
    end

    // two loads with no publish between them
    a_no_overrun: assert property (@(posedge clk48) disable iff (rst)
        (load && fresh) |-> clear)
        else $warning("channel %0d overwritten before publish", chan_index);

endmodule

`default_nettype wire

//--- design/sample_publish.sv
`timescale 1ns/1ns
`default_nettype none

module sample_publish #(
    parameter int NCH = 2
) (
    input  wire                                      clk48,
    input  wire                                      rst,
    input  wire                                      psel,
    input  wire  [NCH-1:0][qsnd_pkg::word_w-1:0]     held,
    output logic [qsnd_pkg::word_w-1:0]              left,
    output logic [qsnd_pkg::word_w-1:0]              right,
    output logic                                     sample,
    output logic                                     clear
);

    logic last_psel;
    logic frame;

    assign frame = psel && !last_psel;  // new frame starts

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_psel <= 1'b0;
            left      <= '0;
            right     <= '0;
            sample    <= 1'b0;
        end else begin
            last_psel <= psel;
            sample    <= frame;
            if (frame) begin
                left  <= held[0];
                right <= held[1];
            end
        end
    end

    // fresh flags drop together with the sample strobe
    assign clear = sample;

endmodule

`default_nettype wire

//--- design/qsnd_glue_top.sv
`timescale 1ns/1ns
`default_nettype none

module qsnd_glue_top #(
    parameter int TICK_PERIOD = 32000,
    parameter int NCH         = 2
) (
    input  wire                           clk48,
    input  wire                           rst,
    input  wire                           cen8,
    input  wire  [qsnd_pkg::addr_w-1:0]   addr,
    input  wire                           mreq_n,
    input  wire                           rd_n,
    input  wire                           wr_n,
    input  wire                           m1_n,
    input  wire                           iorq_n,
    input  wire  [7:0]                    cpu_dout,
    input  wire  [7:0]                    rom_data,
    input  wire                           pids_n,
    input  wire                           iack,
    input  wire                           sadd,
    input  wire                           psel,
    input  wire  [qsnd_pkg::word_w-1:0]   ser_out,
    output logic [7:0]                    cpu_din,
    output logic                          rom_cs,
    output logic [qsnd_pkg::rom_aw-1:0]   rom_addr,
    output logic                          ram_cs,
    output logic                          int_n,
    output logic                          dsp_rst,
    output logic                          dsp_irq,
    output logic                          dsp_rdy_n,
    output logic [qsnd_pkg::word_w-1:0]   pbus_in,
    output logic [qsnd_pkg::word_w-1:0]   left,
    output logic [qsnd_pkg::word_w-1:0]   right,
    output logic                          sample
);

    logic                                 reg_wr, bank_wr;
    logic [2:0]                           reg_idx;
    logic [7:0]                           reg_data, status;
    logic [qsnd_pkg::bank_w-1:0]          bank;
    logic [NCH-1:0]                       load;
    logic [qsnd_pkg::word_w-1:0]          word;
    logic [NCH-1:0][qsnd_pkg::word_w-1:0] held;
    logic                                 clear;

    assign dsp_rdy_n = status[7];  // same bit the CPU polls

    z80_map_decode u_decode (
        .clk48, .rst, .addr, .mreq_n, .rd_n, .wr_n, .cpu_dout,
        .bank, .status, .rom_data,
        .rom_cs, .rom_addr, .ram_cs, .reg_wr, .bank_wr,
        .stat_rd (), .reg_idx, .reg_data, .cpu_din
    );

    dsp_mailbox u_mailbox (
        .clk48, .rst, .reg_wr, .bank_wr, .reg_idx, .reg_data, .pids_n, .iack,
        .bank, .dsp_rst, .dsp_irq, .pbus_in, .status
    );

    z80_tick_irq #(.TICK_PERIOD(TICK_PERIOD)) u_tick (
        .clk48, .rst, .cen8, .m1_n, .iorq_n, .int_n
    );

    serial_word_steer #(.NCH(NCH)) u_steer (
        .clk48, .rst, .sadd, .psel, .ser_out, .load, .word
    );

    for (genvar i = 0; i < NCH; i++) begin : g_chan
        chan_hold #(.chan_index(i)) u_hold (
            .clk48, .rst,
            .load  (load[i]),
            .word,
            .clear,
            .held  (held[i]),
            .fresh ()
        );
    end

    sample_publish #(.NCH(NCH)) u_publish (
        .clk48, .rst, .psel, .held, .left, .right, .sample, .clear
    );

endmodule

`default_nettype wire

//--- tb/qsnd_glue_tb.sv
`timescale 1ns/1ns
`default_nettype none

module qsnd_glue_tb;

    typedef struct packed {
        logic [3:0]  op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [31:0] exp;
    } entry_t;

    localparam logic [3:0] op_int_wait = 4'd0;
    localparam logic [3:0] op_int_ack  = 4'd1;
    localparam logic [3:0] op_rom      = 4'd2;
    localparam logic [3:0] op_ram_rd   = 4'd3;
    localparam logic [3:0] op_ram_wr   = 4'd4;
    localparam logic [3:0] op_reg_rd   = 4'd5;
    localparam logic [3:0] op_reg_wr   = 4'd6;
    localparam logic [3:0] op_bank     = 4'd7;
    localparam logic [3:0] op_mbox     = 4'd8;  // data[1:0] = {dsp_irq, dsp_rdy_n}
    localparam logic [3:0] op_pids     = 4'd9;
    localparam logic [3:0] op_audio    = 4'd10;

    localparam int n_entries = 25;
    localparam int cyc_limit = 8 * n_entries + 100;

    logic        clk48, rst, cen8, mreq_n, rd_n, wr_n, m1_n, iorq_n;
    logic        pids_n, iack, sadd, psel;
    logic [15:0] addr, ser_out;
    logic [7:0]  cpu_dout, rom_data, cpu_din;
    logic        rom_cs, ram_cs, int_n, dsp_rst, dsp_irq, dsp_rdy_n, sample;
    logic [qsnd_pkg::rom_aw-1:0] rom_addr;
    logic [qsnd_pkg::word_w-1:0] pbus_in, left, right;

    entry_t tbl [n_entries];
    int     errors = 0;
    int     cyc = 0;

    qsnd_glue_top #(.TICK_PERIOD(20), .NCH(2)) dut (
        .clk48, .rst, .cen8, .addr, .mreq_n, .rd_n, .wr_n, .m1_n, .iorq_n,
        .cpu_dout, .rom_data, .pids_n, .iack, .sadd, .psel, .ser_out,
        .cpu_din, .rom_cs, .rom_addr, .ram_cs, .int_n, .dsp_rst, .dsp_irq,
        .dsp_rdy_n, .pbus_in, .left, .right, .sample
    );

    initial begin
        clk48 = 1'b0;
        forever #50 clk48 = ~clk48;
    end

    always @(posedge clk48) begin
        if (!rst)
            cyc++;  // ticks since reset release
    end

    initial begin : watchdog
        wait (cyc >= cyc_limit);
        $display("timeout: run did not finish within %0d cycles", cyc_limit);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // one memory cycle with the selects valid at the return
    task automatic bus_start(input logic [15:0] a, input logic [7:0] d, input logic wr);
        addr     = a;
        cpu_dout = d;
        mreq_n   = 1'b0;
        rd_n     = wr;
        wr_n     = !wr;
        @(negedge clk48);
    endtask

    task automatic bus_end();
        mreq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        @(negedge clk48);  // mailbox has taken the write by now
    endtask

    task automatic send_word(input logic [15:0] w, input logic ch);
        psel    = ch;
        ser_out = w;
        sadd    = 1'b1;
        @(negedge clk48);
        sadd = 1'b0;
        @(negedge clk48);
    endtask

    task automatic play_frame();
        logic [15:0] w0;
        logic [15:0] w1;
        int          pulses;
        w0 = $urandom;
        w1 = $urandom;
        send_word(w0, 1'b0);
        send_word(w1, 1'b1);
        psel = 1'b0;
        @(negedge clk48);
        psel   = 1'b1;  // frame edge
        pulses = 0;
        repeat (3) begin
            @(negedge clk48);
            if (sample)
                pulses++;
        end
        compare("left", left, w0);
        compare("right", right, w1);
        compare("sample pulses", pulses, 1);
    endtask

    task automatic run_entry(input entry_t e);
        case (e.op)
            op_int_wait: begin
                while (int_n)
                    @(negedge clk48);
                compare("ticks to int_n low", cyc, e.exp);
            end
            op_int_ack: begin
                compare("int_n before ack", int_n, 0);
                m1_n   = 1'b0;
                iorq_n = 1'b0;
                @(negedge clk48);
                m1_n   = 1'b1;
                iorq_n = 1'b1;
                compare("int_n after ack", int_n, 1);
            end
            op_rom: begin
                rom_data = e.data;
                bus_start(e.addr, 8'h00, 1'b0);
                compare("rom_cs", rom_cs, 1);
                compare("ram_cs on rom", ram_cs, 0);
                compare("rom_addr", rom_addr, e.exp);
                compare("cpu_din rom", cpu_din, e.data);
                bus_end();
            end
            op_ram_rd, op_ram_wr: begin
                bus_start(e.addr, e.data, e.op == op_ram_wr);
                compare("ram_cs", ram_cs, 1);
                compare("rom_cs on ram", rom_cs, 0);
                bus_end();
            end
            op_reg_rd: begin
                bus_start(e.addr, 8'h00, 1'b0);
                compare("register read", cpu_din, e.exp);
                bus_end();
            end
            op_reg_wr: begin
                bus_start(e.addr, e.data, 1'b1);
                bus_end();
            end
            op_bank: begin
                bus_start(e.addr, e.data, 1'b1);
                bus_end();
                compare("dsp_rst", dsp_rst, e.exp);
            end
            op_mbox: begin
                compare("dsp_irq", dsp_irq, e.data[1]);
                compare("dsp_rdy_n", dsp_rdy_n, e.data[0]);
                compare("pbus_in", pbus_in, e.exp);
            end
            op_pids: begin
                pids_n = 1'b0;
                @(negedge clk48);
                pids_n = 1'b1;  // rising edge ends the DSP read
                @(negedge clk48);
            end
            op_audio: play_frame();
            default: begin
                $display("unknown table operation %0d at %0t ns", e.op, $time);
                errors++;
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'he29fe405));
        rst      = 1'b1;
        cen8     = 1'b1;
        addr     = '0;
        mreq_n   = 1'b1;
        rd_n     = 1'b1;
        wr_n     = 1'b1;
        m1_n     = 1'b1;
        iorq_n   = 1'b1;
        cpu_dout = '0;
        rom_data = '0;
        pids_n   = 1'b1;
        iack     = 1'b0;
        sadd     = 1'b0;
        psel     = 1'b0;
        ser_out  = '0;

        // op, addr, data, expected
        tbl[0]  = {op_int_wait, 16'h0000, 8'h00, 32'd20};
        tbl[1]  = {op_rom,      16'h1234, 8'h5a, 32'h01234};
        tbl[2]  = {op_rom,      16'h7fff, 8'ha5, 32'h07fff};
        tbl[3]  = {op_rom,      16'h8123, 8'h3c, 32'h08123};  // bank 0
        tbl[4]  = {op_bank,     16'hd003, 8'h05, 32'd1};
        tbl[5]  = {op_rom,      16'h9abc, 8'hc3, 32'h1dabc};  // bank 5
        tbl[6]  = {op_reg_rd,   16'hd007, 8'h00, 32'hf5};
        tbl[7]  = {op_bank,     16'hd003, 8'h8f, 32'd0};
        tbl[8]  = {op_rom,      16'hbfff, 8'h77, 32'h47fff};  // bank 15
        tbl[9]  = {op_ram_rd,   16'hc000, 8'h00, 32'd0};
        tbl[10] = {op_ram_wr,   16'hf123, 8'h99, 32'd0};
        tbl[11] = {op_reg_rd,   16'hd004, 8'h00, 32'hff};  // unmapped index
        tbl[12] = {op_reg_rd,   16'he010, 8'h00, 32'hff};
        tbl[13] = {op_bank,     16'hd003, 8'h83, 32'd0};
        tbl[14] = {op_reg_rd,   16'hd007, 8'h00, 32'hf3};
        tbl[15] = {op_reg_wr,   16'hd000, 8'hbe, 32'd0};
        tbl[16] = {op_reg_wr,   16'hd001, 8'hef, 32'd0};
        tbl[17] = {op_reg_wr,   16'hd002, 8'h42, 32'd0};
        tbl[18] = {op_mbox,     16'h0000, 8'h02, 32'h0042};
        tbl[19] = {op_reg_rd,   16'hd007, 8'h00, 32'h73};  // rdy_n low now
        tbl[20] = {op_pids,     16'h0000, 8'h00, 32'd0};
        tbl[21] = {op_mbox,     16'h0000, 8'h01, 32'hbeef};
        tbl[22] = {op_audio,    16'h0000, 8'h00, 32'd0};
        tbl[23] = {op_audio,    16'h0000, 8'h00, 32'd0};
        tbl[24] = {op_int_ack,  16'h0000, 8'h00, 32'd0};

        repeat (2) @(posedge clk48);
        @(negedge clk48);
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++)
            run_entry(tbl[i]);

        $display("run complete: %0d errors", errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/qsnd_pkg.sv
design/z80_map_decode.sv
design/dsp_mailbox.sv
design/z80_tick_irq.sv
design/serial_word_steer.sv
design/chan_hold.sv
design/sample_publish.sv
design/qsnd_glue_top.sv
tb/qsnd_glue_tb.sv

//--- Bender.yml
package:
  name: qsnd_glue

sources:
  - files:
      - design/qsnd_pkg.sv
      - design/z80_map_decode.sv
      - design/dsp_mailbox.sv
      - design/z80_tick_irq.sv
      - design/serial_word_steer.sv
      - design/chan_hold.sv
      - design/sample_publish.sv
      - design/qsnd_glue_top.sv
  - target: test
    files:
      - tb/qsnd_glue_tb.sv
